//--- Bender.yml
package:
  name: mdu

sources:
  - verilog/mdu_pkg.sv
  - verilog/mdu_issue.sv
  - verilog/mdu_muler.sv
  - verilog/mdu_divider.sv
  - verilog/mdu_wb_arbiter.sv
  - verilog/mdu_top.sv
  - target: test
    files:
      - tb/mdu_properties.sv
      - tb/mdu_tb.sv

//--- tb.f
verilog/mdu_pkg.sv
verilog/mdu_issue.sv
verilog/mdu_muler.sv
verilog/mdu_divider.sv
verilog/mdu_wb_arbiter.sv
verilog/mdu_top.sv
tb/mdu_properties.sv
tb/mdu_tb.sv

//--- tb/mdu_properties.sv
`timescale 1ns/10ps

module mdu_properties (
    input logic                            clk,
    input logic                            arst_n_i,
    input logic                            flush_i,
    input logic                            req_ready_i,
    input logic                            wb_valid_i,
    input logic                            wb_ready_i,
    input logic [mdu_pkg::rob_width_c-1:0] wb_reg_id_i,
    input logic [31:0]                     wb_data_i
);

    // A stalled result stays on the port unchanged.
    wb_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_i && !wb_ready_i && !flush_i
        |=> wb_valid_i && $stable(wb_reg_id_i) && $stable(wb_data_i))
    else $error("Writeback valid, tag or data changed while stalled");

    wb_flush_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !wb_valid_i)
    else $error("Writeback valid high in the cycle after flush");

    req_ready_known_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$isunknown(req_ready_i))
    else $error("Request ready is unknown");

endmodule

bind mdu_top mdu_properties u_properties (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush_i),
    .req_ready_i (req_ready_o),
    .wb_valid_i  (wb_valid_o),
    .wb_ready_i  (wb_ready_i),
    .wb_reg_id_i (wb_reg_id_o),
    .wb_data_i   (wb_data_o)
);

//--- tb/mdu_tb.sv
`timescale 1ns/10ps

module mdu_tb;

    import mdu_pkg::*;

    localparam int tags_c    = 2 ** rob_width_c;
    localparam int tbl_len_c = 20;
    localparam int timeout_c = 200;

    logic                   clk;
    logic                   arst_n_i;
    logic                   flush_i;
    logic                   req_valid_i;
    logic                   req_ready_o;
    logic [op_width_c-1:0]  req_op_i;
    logic [31:0]            req_data0_i;
    logic [31:0]            req_data1_i;
    logic [rob_width_c-1:0] req_reg_id_i;
    logic                   wb_valid_o;
    logic                   wb_ready_i;
    logic [rob_width_c-1:0] wb_reg_id_o;
    logic [31:0]            wb_data_o;

    // Scoreboard indexed by tag.
    logic [31:0]            exp_data [tags_c];
    logic                   pending  [tags_c];
    int                     wb_order [tags_c];
    logic [rob_width_c-1:0] next_tag;
    int                     issued_cnt;
    int                     flushed_cnt;
    int                     wb_cnt;
    int                     xfer_cnt;
    int                     err_cnt;
    logic                   timed_out;

    logic [31:0]            op_lfsr;
    logic [31:0]            bp_lfsr;
    logic                   bp_mode;
    logic                   hold_q;
    logic [rob_width_c-1:0] hold_tag;
    logic [31:0]            hold_data;

    // Each entry holds op, operand 0, operand 1 and the random flag.
    logic [67:0] stim [tbl_len_c] = '{
        {mdu_mul_c,   32'h0000_0000, 32'h1234_5678, 1'b0},
        {mdu_mul_c,   32'h0000_0001, 32'hFFFF_FFFF, 1'b0},
        {mdu_mul_c,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0},
        {mdu_mulh_c,  32'h8000_0000, 32'h8000_0000, 1'b0},
        {mdu_mulh_c,  32'h8000_0000, 32'hFFFF_FFFF, 1'b0},
        {mdu_mulh_c,  32'hFFFF_FFFF, 32'h0000_0001, 1'b0},
        {mdu_mulhu_c, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0},
        {mdu_mulhu_c, 32'h8000_0000, 32'h0000_0002, 1'b0},
        {mdu_mul_c,   32'h0,         32'h0,         1'b1},
        {mdu_mulh_c,  32'h0,         32'h0,         1'b1},
        {mdu_mulhu_c, 32'h0,         32'h0,         1'b1},
        {3'd7,        32'h0000_0001, 32'h0000_0002, 1'b0},
        {mdu_div_c,   32'h0,         32'h0,         1'b1},
        {mdu_divu_c,  32'h0,         32'h0,         1'b1},
        {mdu_mod_c,   32'h0,         32'h0,         1'b1},
        {mdu_modu_c,  32'h0,         32'h0,         1'b1},
        {mdu_div_c,   32'h8000_0000, 32'hFFFF_FFFF, 1'b0},
        {mdu_mod_c,   32'h8000_0000, 32'hFFFF_FFFF, 1'b0},
        {mdu_div_c,   32'hFFFF_FFF9, 32'h0000_0000, 1'b0},
        {mdu_modu_c,  32'h1234_5678, 32'h0000_0000, 1'b0}
    };

    mdu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR with taps x^32 + x^31 + x^29 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'hD000_0001 : 32'h0);
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            op_lfsr = lfsr_next(op_lfsr);
            w       = {w[30:0], op_lfsr[0]};
        end
    endtask

    function automatic logic [31:0] expected_result(input logic [op_width_c-1:0] op,
                                                    input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        // At 64 bits min / -1 gives 2^31, whose low word is the dividend.
        case (op)
            mdu_mul_c:   r = sa * sb;
            mdu_mulh_c:  r = (sa * sb) >>> 32;
            mdu_mulhu_c: r = (ua * ub) >> 32;
            mdu_div_c:   r = (b == 32'h0) ? -64'sd1 : sa / sb;
            mdu_divu_c:  r = (b == 32'h0) ? ~64'h0 : ua / ub;
            mdu_mod_c:   r = (b == 32'h0) ? sa : sa % sb;
            mdu_modu_c:  r = (b == 32'h0) ? ua : ua % ub;
            default:     r = 64'h0;
        endcase
        return r[31:0];
    endfunction

    task automatic note_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, timeout_c);
        err_cnt++;
        timed_out = 1'b1;
    endtask

    // Drive one request until accepted. Code 7 expects no result.
    task automatic issue_op(input logic [op_width_c-1:0] op, input logic [31:0] a,
                            input logic [31:0] b);
        int waited;
        waited = 0;
        while (!timed_out && pending[next_tag] && waited < timeout_c) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!timed_out && pending[next_tag]) begin
            note_timeout("free tag");
        end
        if (!timed_out) begin
            req_valid_i  = 1'b1;
            req_op_i     = op;
            req_data0_i  = a;
            req_data1_i  = b;
            req_reg_id_i = next_tag;
            waited       = 0;
            @(negedge clk);
            while (!req_ready_o && waited < timeout_c) begin
                @(negedge clk);
                waited++;
            end
            if (!req_ready_o) begin
                note_timeout("request ready");
                req_valid_i = 1'b0;
            end else begin
                @(posedge clk);
                if (op != 3'd7) begin
                    exp_data[next_tag] = expected_result(op, a, b);
                    pending[next_tag]  = 1'b1;
                    issued_cnt++;
                end
                next_tag++;
                #2;
                req_valid_i = 1'b0;
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (!timed_out && wb_cnt + flushed_cnt < issued_cnt && waited < timeout_c) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!timed_out && wb_cnt + flushed_cnt < issued_cnt) begin
            note_timeout("writeback of all open tags");
        end
    endtask

    // Sampled mid-cycle, where all DUT outputs have settled.
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (hold_q) begin
                assert (wb_valid_o && wb_reg_id_o == hold_tag && wb_data_o == hold_data) else begin
                    $display("Error: wb_data_o = %h tag %h while stalled, held %h tag %h",
                             wb_data_o, wb_reg_id_o, hold_data, hold_tag);
                    err_cnt++;
                end
            end
            hold_q    = wb_valid_o & ~wb_ready_i & ~flush_i;
            hold_tag  = wb_reg_id_o;
            hold_data = wb_data_o;
            if (flush_i) begin
                for (int t = 0; t < tags_c; t++) begin
                    if (pending[t]) begin
                        pending[t] = 1'b0;
                        flushed_cnt++;
                    end
                end
            end else if (wb_valid_o && wb_ready_i) begin
                xfer_cnt++;
                assert (pending[wb_reg_id_o]) else begin
                    $display("Writeback of tag %0d, which has no open request", wb_reg_id_o);
                    err_cnt++;
                end
                if (pending[wb_reg_id_o]) begin
                    assert (wb_data_o === exp_data[wb_reg_id_o]) else begin
                        $display("Error: wb_data_o = %h, expected %h for tag %h",
                                 wb_data_o, exp_data[wb_reg_id_o], wb_reg_id_o);
                        err_cnt++;
                    end
                    pending[wb_reg_id_o]  = 1'b0;
                    wb_order[wb_reg_id_o] = wb_cnt;
                    wb_cnt++;
                end
            end
        end
    end

    // Writeback ready takes one LFSR bit per cycle under back-pressure.
    always @(posedge clk) begin
        if (bp_mode) begin
            #2;
            bp_lfsr    = lfsr_next(bp_lfsr);
            wb_ready_i = bp_lfsr[0];
        end else begin
            #2;
            wb_ready_i = 1'b1;
        end
    end

    initial begin : main_seq
        logic [op_width_c-1:0]  op;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [rob_width_c-1:0] div_tag;
        logic [rob_width_c-1:0] mul_tag;
        arst_n_i     = 1'b0;
        flush_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_op_i     = mdu_mul_c;
        req_data0_i  = '0;
        req_data1_i  = '0;
        req_reg_id_i = '0;
        wb_ready_i   = 1'b1;
        bp_mode      = 1'b0;
        op_lfsr      = 32'd62;
        bp_lfsr      = 32'd62;
        next_tag     = '0;
        issued_cnt   = 0;
        flushed_cnt  = 0;
        wb_cnt       = 0;
        xfer_cnt     = 0;
        err_cnt      = 0;
        timed_out    = 1'b0;
        hold_q       = 1'b0;
        for (int t = 0; t < tags_c; t++) begin
            pending[t]  = 1'b0;
            wb_order[t] = 0;
        end

        repeat (5) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        assert (req_ready_o === 1'b1 && wb_valid_o === 1'b0) else begin
            $display("Error: req_ready_o = %h, wb_valid_o = %h after reset, expected 1 and 0",
                     req_ready_o, wb_valid_o);
            err_cnt++;
        end

        // Corner, random, divide and illegal cases from the table.
        for (int i = 0; i < tbl_len_c; i++) begin
            op = stim[i][67:65];
            a  = stim[i][64:33];
            b  = stim[i][32:1];
            if (stim[i][0]) begin
                rand_word(a);
                rand_word(b);
            end
            issue_op(op, a, b);
        end
        drain();

        // Multiplies behind a divide overtake it.
        issue_op(mdu_div_c, 32'h7654_3210, 32'h0000_0123);
        div_tag = next_tag - 1'b1;
        for (int i = 0; i < 4; i++) begin
            rand_word(a);
            rand_word(b);
            issue_op(mdu_mul_c, a, b);
        end
        mul_tag = next_tag - 1'b1;
        drain();
        assert (wb_order[div_tag] > wb_order[mul_tag]) else begin
            $display("Divide tag %0d finished before the multiplies issued behind it", div_tag);
            err_cnt++;
        end

        bp_mode = 1'b1;
        for (int i = 0; i < 12; i++) begin
            rand_word(a);
            rand_word(b);
            op = (i % 3 == 0) ? mdu_mul_c : ((i % 3 == 1) ? mdu_mulh_c : mdu_mulhu_c);
            issue_op(op, a, b);
        end
        drain();
        bp_mode = 1'b0;

        // Work in flight at flush is dropped.
        issue_op(mdu_div_c, 32'h0000_1000, 32'h0000_0010);
        issue_op(mdu_mul_c, 32'h0000_0003, 32'h0000_0005);
        issue_op(mdu_mulhu_c, 32'hFFFF_0000, 32'h0001_0000);
        flush_i = 1'b1;
        @(posedge clk);
        #2;
        flush_i = 1'b0;
        issue_op(mdu_mulh_c, 32'hFFFF_FFF0, 32'h0000_0010);
        drain();

        // Every transfer on the port counts, so an extra result shows up here.
        assert (xfer_cnt == issued_cnt - flushed_cnt) else begin
            $display("Writeback count %0d differs from %0d issued less %0d flushed",
                     xfer_cnt, issued_cnt, flushed_cnt);
            err_cnt++;
        end
        $display("Writebacks %0d, flushed %0d, errors %0d", xfer_cnt, flushed_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog/mdu_divider.sv
`timescale 1ns/10ps

module mdu_divider (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            flush_i,

    input  logic                            valid_i,
    output logic                            ready_o,
    input  logic [mdu_pkg::op_width_c-1:0]  op_i,
    input  logic [31:0]                     data0_i,
    input  logic [31:0]                     data1_i,
    input  logic [mdu_pkg::rob_width_c-1:0] reg_id_i,

    output logic                            valid_o,
    input  logic                            ready_i,
    output logic [mdu_pkg::rob_width_c-1:0] reg_id_o,
    output logic [31:0]                     data_o
);

    import mdu_pkg::*;

    logic                       busy_q;
    logic                       valid_q;
    logic [div_cnt_width_c-1:0] step_q;

    logic                       accept;
    logic                       running;
    logic                       last_step;

    logic                       is_signed;
    logic                       is_rem;
    logic [31:0]                abs0;
    logic [31:0]                abs1;

    logic                       is_rem_q;
    logic                       neg_quot_q;
    logic                       neg_rem_q;
    logic [rob_width_c-1:0]     reg_id_q;
    logic [31:0]                divisor_q;
    logic [31:0]                quot_q;
    logic [31:0]                rem_q;
    logic [31:0]                result_q;

    logic [32:0]                partial;
    logic [33:0]                diff;
    logic [31:0]                quot_fix;
    logic [31:0]                rem_fix;

    // One item at a time, released when the result is taken.
    assign accept    = valid_i & ~busy_q;
    assign ready_o   = ~busy_q;
    assign running   = busy_q & ~valid_q;
    assign last_step = (step_q == div_cnt_width_c'(div_steps_c));

    assign is_signed = (op_i == mdu_div_c) | (op_i == mdu_mod_c);
    assign is_rem    = (op_i == mdu_mod_c) | (op_i == mdu_modu_c);
    assign abs0      = (is_signed & data0_i[31]) ? -data0_i : data0_i;
    assign abs1      = (is_signed & data1_i[31]) ? -data1_i : data1_i;

    // Restoring step on the magnitudes.
    assign partial = {rem_q, quot_q[31]};
    assign diff    = {1'b0, partial} - {2'b00, divisor_q};

    // Min / -1 needs no special case. The magnitude quotient 2^31 negates to itself.
    assign quot_fix = neg_quot_q ? -quot_q : quot_q;
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            step_q  <= '0;
        end else if (flush_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            step_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            step_q <= '0;
        end else if (running) begin
            if (last_step) begin
                valid_q <= 1'b1;
            end else begin
                step_q <= step_q + div_cnt_width_c'(1);
            end
        end else if (valid_q && ready_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            is_rem_q  <= is_rem;
            reg_id_q  <= reg_id_i;
            divisor_q <= abs1;
            quot_q    <= abs0;
            rem_q     <= '0;
            // Division by zero keeps the quotient at all ones.
            neg_quot_q <= is_signed & (data0_i[31] ^ data1_i[31]) & (data1_i != '0);
            neg_rem_q  <= is_signed & data0_i[31];
        end else if (running) begin
            if (last_step) begin
                result_q <= is_rem_q ? rem_fix : quot_fix;
            end else if (!diff[33]) begin
                rem_q  <= diff[31:0];
                quot_q <= {quot_q[30:0], 1'b1};
            end else begin
                rem_q  <= partial[31:0];
                quot_q <= {quot_q[30:0], 1'b0};
            end
        end
    end

    assign valid_o  = valid_q;
    assign reg_id_o = reg_id_q;
    assign data_o   = result_q;

endmodule

//--- verilog/mdu_issue.sv
`timescale 1ns/10ps

module mdu_issue (
    input  logic                           req_valid_i,
    input  logic [mdu_pkg::op_width_c-1:0] req_op_i,
    output logic                           req_ready_o,

    output logic                           mul_valid_o,
    input  logic                           mul_ready_i,

    output logic                           div_valid_o,
    input  logic                           div_ready_i
);

    import mdu_pkg::*;

    logic is_mul;
    logic is_div;

    // Operation class.
    always_comb begin
        is_mul = 1'b0;
        is_div = 1'b0;
        case (req_op_i)
            mdu_mul_c,
            mdu_mulh_c,
            mdu_mulhu_c: begin
                is_mul = 1'b1;
            end
            mdu_div_c,
            mdu_divu_c,
            mdu_mod_c,
            mdu_modu_c: begin
                is_div = 1'b1;
            end
            default: begin
                is_mul = 1'b0;
                is_div = 1'b0;
            end
        endcase
    end

    assign mul_valid_o = req_valid_i & is_mul;
    assign div_valid_o = req_valid_i & is_div;

    // Illegal codes are always ready, so they are swallowed.
    always_comb begin
        if (is_mul) begin
            req_ready_o = mul_ready_i;
        end else if (is_div) begin
            req_ready_o = div_ready_i;
        end else begin
            req_ready_o = 1'b1;
        end
    end

endmodule

//--- verilog/mdu_muler.sv
`timescale 1ns/10ps

module mdu_muler (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            flush_i,

    input  logic                            valid_i,
    output logic                            ready_o,
    input  logic [mdu_pkg::op_width_c-1:0]  op_i,
    input  logic [31:0]                     data0_i,
    input  logic [31:0]                     data1_i,
    input  logic [mdu_pkg::rob_width_c-1:0] reg_id_i,

    output logic                            valid_o,
    input  logic                            ready_i,
    output logic [mdu_pkg::rob_width_c-1:0] reg_id_o,
    output logic [31:0]                     data_o
);

    import mdu_pkg::*;

    logic                   advance;

    logic                   valid_s1;
    logic                   valid_s2;
    logic                   valid_s3;

    logic [op_width_c-1:0]  op_s1;
    logic [op_width_c-1:0]  op_s2;
    logic [op_width_c-1:0]  op_s3;

    logic [rob_width_c-1:0] reg_id_s1;
    logic [rob_width_c-1:0] reg_id_s2;
    logic [rob_width_c-1:0] reg_id_s3;

    logic [32:0]            r0_s1;
    logic [32:0]            r1_s1;
    (* use_dsp = "yes" *) logic [65:0] prod_s2;
    logic [65:0]            prod_s3;

    logic                   sext;

    // The whole pipe moves when the last stage is empty or leaving.
    assign advance = ~valid_s3 | ready_i;
    assign ready_o = advance;

    // MULHU treats both operands as unsigned.
    assign sext = (op_i != mdu_mulhu_c);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
        end else if (flush_i) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
        end else if (advance) begin
            valid_s1 <= valid_i;
            valid_s2 <= valid_s1;
            valid_s3 <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            // Stage 1: widen operands to 33 bits.
            op_s1     <= op_i;
            reg_id_s1 <= reg_id_i;
            r0_s1     <= {sext & data0_i[31], data0_i};
            r1_s1     <= {sext & data1_i[31], data1_i};

            // Stage 2: signed product.
            op_s2     <= op_s1;
            reg_id_s2 <= reg_id_s1;
            prod_s2   <= $signed(r0_s1) * $signed(r1_s1);

            // Stage 3: output register.
            op_s3     <= op_s2;
            reg_id_s3 <= reg_id_s2;
            prod_s3   <= prod_s2;
        end
    end

    assign valid_o  = valid_s3;
    assign reg_id_o = reg_id_s3;

    // Low word for MUL, high word for both high variants.
    assign data_o = (op_s3 == mdu_mul_c) ? prod_s3[31:0] : prod_s3[63:32];

endmodule

//--- verilog/mdu_pkg.sv
package mdu_pkg;

    // Reorder-buffer tag width.
    localparam int rob_width_c = 6;

    // Operation code width.
    localparam int op_width_c = 3;

    // Multiply group, served by the pipelined multiplier.
    localparam logic [op_width_c-1:0] mdu_mul_c   = 3'd0;
    localparam logic [op_width_c-1:0] mdu_mulh_c  = 3'd1;
    localparam logic [op_width_c-1:0] mdu_mulhu_c = 3'd2;

    // Divide group, served by the iterative divider.
    localparam logic [op_width_c-1:0] mdu_div_c   = 3'd3;
    localparam logic [op_width_c-1:0] mdu_divu_c  = 3'd4;
    localparam logic [op_width_c-1:0] mdu_mod_c   = 3'd5;
    localparam logic [op_width_c-1:0] mdu_modu_c  = 3'd6;

    // Code 7 is illegal.

    // One quotient bit per iteration.
    localparam int div_steps_c = 32;

    // Iteration counter must reach div_steps_c itself.
    localparam int div_cnt_width_c = $clog2(div_steps_c + 1);

endpackage

//--- verilog/mdu_top.sv
`timescale 1ns/10ps

module mdu_top (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            flush_i,

    input  logic                            req_valid_i,
    output logic                            req_ready_o,
    input  logic [mdu_pkg::op_width_c-1:0]  req_op_i,
    input  logic [31:0]                     req_data0_i,
    input  logic [31:0]                     req_data1_i,
    input  logic [mdu_pkg::rob_width_c-1:0] req_reg_id_i,

    output logic                            wb_valid_o,
    input  logic                            wb_ready_i,
    output logic [mdu_pkg::rob_width_c-1:0] wb_reg_id_o,
    output logic [31:0]                     wb_data_o
);

    import mdu_pkg::*;

    logic                   mul_req_valid;
    logic                   mul_req_ready;
    logic                   div_req_valid;
    logic                   div_req_ready;

    logic                   mul_res_valid;
    logic                   mul_res_ready;
    logic [rob_width_c-1:0] mul_res_reg_id;
    logic [31:0]            mul_res_data;

    logic                   div_res_valid;
    logic                   div_res_ready;
    logic [rob_width_c-1:0] div_res_reg_id;
    logic [31:0]            div_res_data;

    mdu_issue u_issue (
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_ready_o (req_ready_o),
        .mul_valid_o (mul_req_valid),
        .mul_ready_i (mul_req_ready),
        .div_valid_o (div_req_valid),
        .div_ready_i (div_req_ready)
    );

    // Operands and tag fan out to both units.
    mdu_muler u_muler (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .valid_i  (mul_req_valid),
        .ready_o  (mul_req_ready),
        .op_i     (req_op_i),
        .data0_i  (req_data0_i),
        .data1_i  (req_data1_i),
        .reg_id_i (req_reg_id_i),
        .valid_o  (mul_res_valid),
        .ready_i  (mul_res_ready),
        .reg_id_o (mul_res_reg_id),
        .data_o   (mul_res_data)
    );

    mdu_divider u_divider (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .valid_i  (div_req_valid),
        .ready_o  (div_req_ready),
        .op_i     (req_op_i),
        .data0_i  (req_data0_i),
        .data1_i  (req_data1_i),
        .reg_id_i (req_reg_id_i),
        .valid_o  (div_res_valid),
        .ready_i  (div_res_ready),
        .reg_id_o (div_res_reg_id),
        .data_o   (div_res_data)
    );

    mdu_wb_arbiter u_wb_arbiter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .mul_valid_i  (mul_res_valid),
        .mul_ready_o  (mul_res_ready),
        .mul_reg_id_i (mul_res_reg_id),
        .mul_data_i   (mul_res_data),
        .div_valid_i  (div_res_valid),
        .div_ready_o  (div_res_ready),
        .div_reg_id_i (div_res_reg_id),
        .div_data_i   (div_res_data),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_reg_id_o  (wb_reg_id_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

//--- verilog/mdu_wb_arbiter.sv
`timescale 1ns/10ps

module mdu_wb_arbiter (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            flush_i,

    input  logic                            mul_valid_i,
    output logic                            mul_ready_o,
    input  logic [mdu_pkg::rob_width_c-1:0] mul_reg_id_i,
    input  logic [31:0]                     mul_data_i,

    input  logic                            div_valid_i,
    output logic                            div_ready_o,
    input  logic [mdu_pkg::rob_width_c-1:0] div_reg_id_i,
    input  logic [31:0]                     div_data_i,

    output logic                            wb_valid_o,
    input  logic                            wb_ready_i,
    output logic [mdu_pkg::rob_width_c-1:0] wb_reg_id_o,
    output logic [31:0]                     wb_data_o
);

    // Pointer low favours the multiplier, high favours the divider.
    logic prio_div_q;
    logic grant_mul;
    logic grant_div;
    logic xfer;

    assign grant_mul = mul_valid_i & (~prio_div_q | ~div_valid_i);
    assign grant_div = div_valid_i & (prio_div_q | ~mul_valid_i);

    assign wb_valid_o  = mul_valid_i | div_valid_i;
    assign wb_reg_id_o = grant_div ? div_reg_id_i : mul_reg_id_i;
    assign wb_data_o   = grant_div ? div_data_i : mul_data_i;

    // Only the granted unit sees the ready.
    assign mul_ready_o = grant_mul & wb_ready_i;
    assign div_ready_o = grant_div & wb_ready_i;

    assign xfer = wb_valid_o & wb_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_div_q <= 1'b0;
        end else if (flush_i) begin
            prio_div_q <= 1'b0;
        end else if (xfer) begin
            // Hand priority to the unit that lost.
            prio_div_q <= grant_mul;
        end
    end

endmodule
